//--- source/quad_bram_pkg.sv
package quad_bram_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int BRAM_DEPTH     = 1024;
    localparam int COORD_W        = $clog2(BRAM_DEPTH) - 1;
    localparam int SEQ_ADDR_W     = 12;
    localparam int NUM_AWE        = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int SEQ_DEPTH      = 2560;
    localparam int SEQ_RD_LATENCY = 3;
    localparam int READS_PER_COL  = 5;
    localparam int PRIME_ROWS     = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [COORD_W-1:0]    coord_t;
    typedef logic [SEQ_ADDR_W-1:0] seq_addr_t;
    typedef logic [8:0]            pfb_count_t;
    typedef logic [2:0]            cyc_t;
    typedef logic [1:0]            gray_t;

    // Both fields are last indices, not counts
    typedef struct packed {
        coord_t num_input_cols;
        coord_t num_input_rows;
    } job_cfg_t;

    typedef struct packed {
        logic      rden;
        seq_addr_t addr;
    } seq_rd_t;

    typedef struct packed {
        coord_t row;
        coord_t col;
    } in_pos_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRIME,
        ST_WAIT_PFB_LOAD,
        ST_ACTIVE,
        ST_WAIT_JOB_DONE,
        ST_SEND_COMPLETE
    } ctrl_state_e;

endpackage

//--- source/layer_ctrl_fsm.sv
`timescale 1ns/1ps

module layer_ctrl_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    job_start,
    input  quad_bram_pkg::job_cfg_t cfg,
    input  logic                    fetch_done,
    input  logic                    drain_idle,
    input  quad_bram_pkg::in_pos_t  in_pos,
    input  logic                    row_done,
    input  logic                    last_row,
    input  logic                    pipeline_flushed,
    input  logic                    complete_done,
    output logic                    job_accept,
    output logic                    fetch_start,
    output logic                    scan_row,
    output logic                    complete_start
);

    quad_bram_pkg::ctrl_state_e state;
    logic                       pfb_loaded;
    logic                       more_prime;

    // Keep priming while rows remain, but never past the last input row
    assign more_prime = (in_pos.row < quad_bram_pkg::coord_t'(quad_bram_pkg::PRIME_ROWS)) &&
                        (in_pos.row <= cfg.num_input_rows);

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= quad_bram_pkg::ST_IDLE;
            pfb_loaded     <= 1'b0;
            job_accept     <= 1'b0;
            fetch_start    <= 1'b0;
            scan_row       <= 1'b0;
            complete_start <= 1'b0;
        end else begin
            job_accept     <= 1'b0;
            fetch_start    <= 1'b0;
            scan_row       <= 1'b0;
            complete_start <= 1'b0;

            case (state)
                quad_bram_pkg::ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= quad_bram_pkg::ST_PRIME;
                    end
                end

                quad_bram_pkg::ST_PRIME: begin
                    fetch_start <= 1'b1;
                    state       <= quad_bram_pkg::ST_WAIT_PFB_LOAD;
                end

                // Fetch lands first, then the buffer drains out
                quad_bram_pkg::ST_WAIT_PFB_LOAD: begin
                    if (fetch_done) begin
                        pfb_loaded <= 1'b1;
                    end else if (pfb_loaded && drain_idle) begin
                        pfb_loaded <= 1'b0;
                        if (more_prime) begin
                            state <= quad_bram_pkg::ST_PRIME;
                        end else begin
                            scan_row <= 1'b1;
                            state    <= quad_bram_pkg::ST_ACTIVE;
                        end
                    end
                end

                quad_bram_pkg::ST_ACTIVE: begin
                    if (row_done) begin
                        if (last_row) begin
                            state <= quad_bram_pkg::ST_WAIT_JOB_DONE;
                        end else begin
                            // One more input row per output row
                            fetch_start <= 1'b1;
                            state       <= quad_bram_pkg::ST_WAIT_PFB_LOAD;
                        end
                    end
                end

                quad_bram_pkg::ST_WAIT_JOB_DONE: begin
                    if (pipeline_flushed) begin
                        complete_start <= 1'b1;
                        state          <= quad_bram_pkg::ST_SEND_COMPLETE;
                    end
                end

                quad_bram_pkg::ST_SEND_COMPLETE: begin
                    if (complete_done) begin
                        state <= quad_bram_pkg::ST_IDLE;
                    end
                end

                default: begin
                    state <= quad_bram_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/fetch_handshake.sv
`timescale 1ns/1ps

module fetch_handshake (
    input  logic clk,
    input  logic rst,
    input  logic fetch_start,
    input  logic job_fetch_ack,
    input  logic job_fetch_complete,
    input  logic complete_start,
    input  logic job_complete_ack,
    output logic job_fetch_request,
    output logic job_fetch_in_progress,
    output logic fetch_done,
    output logic job_complete,
    output logic complete_done
);

    // Completion only counts while a fetch is underway
    assign fetch_done = job_fetch_complete && job_fetch_in_progress;

    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_request     <= 1'b0;
            job_fetch_in_progress <= 1'b0;
            job_complete          <= 1'b0;
            complete_done         <= 1'b0;
        end else begin
            if (fetch_start) begin
                job_fetch_request <= 1'b1;
            end else if (job_fetch_ack) begin
                job_fetch_request <= 1'b0;
            end

            if (job_fetch_ack && job_fetch_request) begin
                job_fetch_in_progress <= 1'b1;
            end else if (job_fetch_complete) begin
                job_fetch_in_progress <= 1'b0;
            end

            ////////////////////////////////////////////////////////////////////////////
            // Job complete exchange
            ////////////////////////////////////////////////////////////////////////////

            if (complete_start) begin
                job_complete <= 1'b1;
            end else if (job_complete_ack) begin
                job_complete <= 1'b0;
            end

            complete_done <= job_complete && job_complete_ack;
        end
    end

endmodule

//--- source/pfb_drain.sv
`timescale 1ns/1ps

module pfb_drain (
    input  logic                      clk,
    input  logic                      rst,
    input  quad_bram_pkg::job_cfg_t   cfg,
    input  logic                      fetch_done,
    input  quad_bram_pkg::pfb_count_t pfb_full_count,
    input  logic                      job_start,
    output logic                      pfb_rden,
    output quad_bram_pkg::in_pos_t    in_pos,
    output logic                      drain_idle
);

    quad_bram_pkg::pfb_count_t pfb_count;

    assign drain_idle = (pfb_count == '0);
    assign pfb_rden   = !drain_idle;

    // Occupancy, one pixel leaves per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else if (fetch_done) begin
            pfb_count <= pfb_full_count;
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - 1'b1;
        end
    end

    // Input position steps per pixel read
    always_ff @(posedge clk) begin
        if (rst) begin
            in_pos <= '0;
        end else if (job_start) begin
            in_pos <= '0;
        end else if (pfb_rden) begin
            if (in_pos.col == cfg.num_input_cols) begin
                in_pos.col <= '0;
                in_pos.row <= in_pos.row + 1'b1;
            end else begin
                in_pos.col <= in_pos.col + 1'b1;
            end
        end
    end

endmodule

//--- source/seq_scan.sv
`timescale 1ns/1ps

module seq_scan #(
    parameter int SEQ_DEPTH = quad_bram_pkg::SEQ_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  quad_bram_pkg::job_cfg_t cfg,
    input  logic                    job_start,
    input  logic                    scan_row,
    input  logic                    complete_done,
    output quad_bram_pkg::seq_rd_t  seq_rd,
    output quad_bram_pkg::cyc_t     cycle_counter,
    output quad_bram_pkg::gray_t    gray_code,
    output logic                    row_done,
    output logic                    last_row
);

    quad_bram_pkg::coord_t out_col;
    quad_bram_pkg::coord_t row_count;
    quad_bram_pkg::coord_t last_row_idx;
    logic                  col_end;
    logic                  row_end;

    // Output rows run from 0 to num_input_rows-2
    assign last_row_idx = cfg.num_input_rows - quad_bram_pkg::coord_t'(2);

    assign col_end = seq_rd.rden &&
                     (cycle_counter == quad_bram_pkg::cyc_t'(quad_bram_pkg::READS_PER_COL - 1));
    assign row_end = col_end && (out_col == cfg.num_input_cols);

    // Phase of completed rows mod 4
    assign gray_code = {row_count[1], row_count[1] ^ row_count[0]};

    ////////////////////////////////////////////////////////////////////////////
    // Sequence BRAM read stream
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rd   <= '0;
            row_done <= 1'b0;
            last_row <= 1'b0;
        end else begin
            row_done <= row_end;
            last_row <= row_end && (row_count == last_row_idx);

            if (scan_row) begin
                seq_rd.rden <= 1'b1;
            end else if (row_end) begin
                seq_rd.rden <= 1'b0;
            end

            // Address wraps at the sequence depth
            if (complete_done) begin
                seq_rd.addr <= '0;
            end else if (seq_rd.rden) begin
                if (seq_rd.addr == quad_bram_pkg::seq_addr_t'(SEQ_DEPTH - 1)) begin
                    seq_rd.addr <= '0;
                end else begin
                    seq_rd.addr <= seq_rd.addr + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output position
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || job_start) begin
            cycle_counter <= '0;
            out_col       <= '0;
        end else begin
            if (col_end) begin
                cycle_counter <= '0;
            end else if (seq_rd.rden) begin
                cycle_counter <= cycle_counter + 1'b1;
            end

            if (row_end) begin
                out_col <= '0;
            end else if (col_end) begin
                out_col <= out_col + 1'b1;
            end
        end
    end

    // Row count also drops back once the job is reported done
    always_ff @(posedge clk) begin
        if (rst || job_start || complete_done) begin
            row_count <= '0;
        end else if (row_end) begin
            row_count <= row_count + 1'b1;
        end
    end

endmodule

//--- source/ce_launch_chain.sv
`timescale 1ns/1ps

module ce_launch_chain #(
    parameter int NUM_CE = quad_bram_pkg::NUM_AWE * quad_bram_pkg::NUM_CE_PER_AWE
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              seq_rden,
    input  logic              row_done,
    output logic [NUM_CE-1:0] ce_execute,
    output logic [NUM_CE-1:0] next_kernel
);

    // First execute stage supplies the last cycle of read latency
    localparam int DLY = quad_bram_pkg::SEQ_RD_LATENCY - 1;

    logic [DLY-1:0] rden_dly;

    always_ff @(posedge clk) begin
        if (rst) begin
            rden_dly    <= '0;
            ce_execute  <= '0;
            next_kernel <= '0;
        end else begin
            rden_dly    <= (rden_dly << 1) | DLY'(seq_rden);
            // Each CE starts one cycle after its neighbour
            ce_execute  <= (ce_execute << 1) | NUM_CE'(rden_dly[DLY-1]);
            next_kernel <= (next_kernel << 1) | NUM_CE'(row_done);
        end
    end

endmodule

//--- source/quad_bram_ctrl.sv
`timescale 1ns/1ps

module quad_bram_ctrl #(
    parameter int NUM_CE    = quad_bram_pkg::NUM_AWE * quad_bram_pkg::NUM_CE_PER_AWE,
    parameter int SEQ_DEPTH = quad_bram_pkg::SEQ_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      job_start,
    input  quad_bram_pkg::job_cfg_t   cfg,
    output logic                      job_accept,
    output logic                      job_fetch_request,
    output logic                      job_fetch_in_progress,
    input  logic                      job_fetch_ack,
    input  logic                      job_fetch_complete,
    input  quad_bram_pkg::pfb_count_t pfb_full_count,
    output logic                      pfb_rden,
    output quad_bram_pkg::in_pos_t    in_pos,
    output quad_bram_pkg::seq_rd_t    seq_rd,
    output quad_bram_pkg::cyc_t       cycle_counter,
    output quad_bram_pkg::gray_t      gray_code,
    output logic [NUM_CE-1:0]         ce_execute,
    output logic [NUM_CE-1:0]         next_kernel,
    input  logic                      pipeline_flushed,
    output logic                      job_complete,
    input  logic                      job_complete_ack
);

    logic fetch_start;
    logic fetch_done;
    logic scan_row;
    logic row_done;
    logic last_row;
    logic drain_idle;
    logic complete_start;
    logic complete_done;

    layer_ctrl_fsm i_fsm (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .cfg              (cfg),
        .fetch_done       (fetch_done),
        .drain_idle       (drain_idle),
        .in_pos           (in_pos),
        .row_done         (row_done),
        .last_row         (last_row),
        .pipeline_flushed (pipeline_flushed),
        .complete_done    (complete_done),
        .job_accept       (job_accept),
        .fetch_start      (fetch_start),
        .scan_row         (scan_row),
        .complete_start   (complete_start)
    );

    fetch_handshake i_handshake (
        .clk                   (clk),
        .rst                   (rst),
        .fetch_start           (fetch_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .complete_start        (complete_start),
        .job_complete_ack      (job_complete_ack),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .fetch_done            (fetch_done),
        .job_complete          (job_complete),
        .complete_done         (complete_done)
    );

    pfb_drain i_drain (
        .clk            (clk),
        .rst            (rst),
        .cfg            (cfg),
        .fetch_done     (fetch_done),
        .pfb_full_count (pfb_full_count),
        .job_start      (job_start),
        .pfb_rden       (pfb_rden),
        .in_pos         (in_pos),
        .drain_idle     (drain_idle)
    );

    seq_scan #(
        .SEQ_DEPTH (SEQ_DEPTH)
    ) i_scan (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg),
        .job_start     (job_start),
        .scan_row      (scan_row),
        .complete_done (complete_done),
        .seq_rd        (seq_rd),
        .cycle_counter (cycle_counter),
        .gray_code     (gray_code),
        .row_done      (row_done),
        .last_row      (last_row)
    );

    ce_launch_chain #(
        .NUM_CE (NUM_CE)
    ) i_launch (
        .clk         (clk),
        .rst         (rst),
        .seq_rden    (seq_rd.rden),
        .row_done    (row_done),
        .ce_execute  (ce_execute),
        .next_kernel (next_kernel)
    );

endmodule

//--- bench/ctrl_ref_model.sv
`timescale 1ns/1ps

module ctrl_ref_model #(
    parameter int NUM_CE    = quad_bram_pkg::NUM_AWE * quad_bram_pkg::NUM_CE_PER_AWE,
    parameter int SEQ_DEPTH = quad_bram_pkg::SEQ_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     job_start,
    input  quad_bram_pkg::job_cfg_t  cfg,
    input  logic                     job_complete_ack,
    input  logic                     seq_rden,
    output quad_bram_pkg::seq_addr_t exp_addr,
    output quad_bram_pkg::cyc_t      exp_cyc,
    output quad_bram_pkg::gray_t     exp_gray,
    output logic [NUM_CE-1:0]        exp_ce,
    output logic [NUM_CE-1:0]        exp_nk
);

    // History bit k holds the read enable from k+1 cycles back
    localparam int HIST = quad_bram_pkg::SEQ_RD_LATENCY + NUM_CE - 1;

    logic [HIST-1:0] rden_hist;
    logic            ack_seen;
    logic            row_last;
    int              row_reads;
    int              rows_done;
    int              row_len;
    int              phase;

    assign row_len = (int'(cfg.num_input_cols) + 1) * quad_bram_pkg::READS_PER_COL;
    assign phase   = rows_done % 4;
    assign exp_gray = quad_bram_pkg::gray_t'(phase ^ (phase >> 1));
    assign exp_ce   = rden_hist[HIST-1 -: NUM_CE];

    always @(posedge clk) begin
        if (rst) begin
            rden_hist <= '0;
            exp_addr  <= '0;
            exp_cyc   <= '0;
            exp_nk    <= '0;
            ack_seen  <= 1'b0;
            row_last  <= 1'b0;
            row_reads <= 0;
            rows_done <= 0;
        end else begin
            rden_hist <= {rden_hist[HIST-2:0], seq_rden};
            exp_nk    <= {exp_nk[NUM_CE-2:0], row_last};
            ack_seen  <= job_complete_ack;
            row_last  <= 1'b0;

            // Host acknowledge closes the job one cycle later
            if (ack_seen) begin
                exp_addr <= '0;
            end else if (seq_rden) begin
                exp_addr <= (exp_addr == SEQ_DEPTH - 1) ? '0 : exp_addr + 1'b1;
            end

            if (job_start) begin
                exp_cyc   <= '0;
                row_reads <= 0;
                rows_done <= 0;
            end else if (seq_rden) begin
                exp_cyc <= (exp_cyc == quad_bram_pkg::READS_PER_COL - 1) ? '0 : exp_cyc + 1'b1;
                if (row_reads == row_len - 1) begin
                    row_reads <= 0;
                    rows_done <= rows_done + 1;
                    row_last  <= 1'b1;
                end else begin
                    row_reads <= row_reads + 1;
                end
            end else if (ack_seen) begin
                rows_done <= 0;
            end
        end
    end

endmodule

//--- bench/tb_quad_bram_ctrl.sv
`timescale 1ns/1ps

module tb_quad_bram_ctrl;

    localparam int NUM_CE    = quad_bram_pkg::NUM_AWE * quad_bram_pkg::NUM_CE_PER_AWE;
    // Shallow sequence memory so the read address wraps within a job
    localparam int SEQ_DEPTH = 97;
    localparam int NUM_JOBS  = 6;
    // Worst job is 10 columns by 8 input rows with 8 fetches
    localparam int JOB_CYCLES = 10 * 8 * (quad_bram_pkg::READS_PER_COL + 8) + 8 * (5 + 8 + 4) + 40;
    localparam int WATCHDOG_CYCLES = 16 + NUM_JOBS * JOB_CYCLES;

    logic                      clk = 1'b0;
    logic                      rst = 1'b1;
    logic                      job_start = 1'b0;
    quad_bram_pkg::job_cfg_t   cfg = '0;
    logic                      job_fetch_ack = 1'b0;
    logic                      job_fetch_complete = 1'b0;
    quad_bram_pkg::pfb_count_t pfb_full_count = '0;
    logic                      job_complete_ack = 1'b0;
    logic                      pipeline_flushed = 1'b0;

    logic                      job_accept;
    logic                      job_fetch_request;
    logic                      job_fetch_in_progress;
    logic                      pfb_rden;
    quad_bram_pkg::in_pos_t    in_pos;
    quad_bram_pkg::seq_rd_t    seq_rd;
    quad_bram_pkg::cyc_t       cycle_counter;
    quad_bram_pkg::gray_t      gray_code;
    logic [NUM_CE-1:0]         ce_execute;
    logic [NUM_CE-1:0]         next_kernel;
    logic                      job_complete;

    quad_bram_pkg::seq_addr_t  exp_addr;
    quad_bram_pkg::cyc_t       exp_cyc;
    quad_bram_pkg::gray_t      exp_gray;
    logic [NUM_CE-1:0]         exp_ce;
    logic [NUM_CE-1:0]         exp_nk;

    integer seed = 32'he47f10a6;
    int     mismatches = 0;
    int     failures = 0;
    int     n_accept = 0;
    int     n_req = 0;
    int     n_pix = 0;
    int     n_reads = 0;
    int     n_complete = 0;
    logic   prev_req = 1'b0;
    logic   prev_complete = 1'b0;
    logic   exp_busy = 1'b0;

    always #50 clk = ~clk;

    quad_bram_ctrl #(
        .NUM_CE    (NUM_CE),
        .SEQ_DEPTH (SEQ_DEPTH)
    ) i_dut (
        .clk                   (clk),
        .rst                   (rst),
        .job_start             (job_start),
        .cfg                   (cfg),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .pfb_full_count        (pfb_full_count),
        .pfb_rden              (pfb_rden),
        .in_pos                (in_pos),
        .seq_rd                (seq_rd),
        .cycle_counter         (cycle_counter),
        .gray_code             (gray_code),
        .ce_execute            (ce_execute),
        .next_kernel           (next_kernel),
        .pipeline_flushed      (pipeline_flushed),
        .job_complete          (job_complete),
        .job_complete_ack      (job_complete_ack)
    );

    ctrl_ref_model #(
        .NUM_CE    (NUM_CE),
        .SEQ_DEPTH (SEQ_DEPTH)
    ) i_model (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .cfg              (cfg),
        .job_complete_ack (job_complete_ack),
        .seq_rden         (seq_rd.rden),
        .exp_addr         (exp_addr),
        .exp_cyc          (exp_cyc),
        .exp_gray         (exp_gray),
        .exp_ce           (exp_ce),
        .exp_nk           (exp_nk)
    );

    function automatic int pick(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        mismatches++;
        $display("Mismatch %s at %0t: expected %h, actual %h", name, $time, exp_val, act_val);
    endtask

    task automatic note_failure(input string msg);
        failures++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle checks at the falling edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : monitor
        int row_len;
        row_len = int'(cfg.num_input_cols) + 1;
        if (!rst) begin
            if (seq_rd.addr !== exp_addr) flag_mismatch("seq_rd.addr", exp_addr, seq_rd.addr);
            if (cycle_counter !== exp_cyc) flag_mismatch("cycle_counter", exp_cyc, cycle_counter);
            if (gray_code !== exp_gray) flag_mismatch("gray_code", exp_gray, gray_code);
            if (ce_execute !== exp_ce) flag_mismatch("ce_execute", exp_ce, ce_execute);
            if (next_kernel !== exp_nk) flag_mismatch("next_kernel", exp_nk, next_kernel);
            if (job_fetch_in_progress !== exp_busy)
                flag_mismatch("job_fetch_in_progress", exp_busy, job_fetch_in_progress);
            // Busy from the cycle after ack until the cycle after complete
            if (job_fetch_ack) begin
                exp_busy = 1'b1;
            end else if (job_fetch_complete) begin
                exp_busy = 1'b0;
            end
            if (job_start) begin
                n_accept   = 0;
                n_req      = 0;
                n_pix      = 0;
                n_reads    = 0;
                n_complete = 0;
            end else begin
                // Position reflects every pixel read so far
                if (in_pos.col !== quad_bram_pkg::coord_t'(n_pix % row_len))
                    flag_mismatch("in_pos.col", n_pix % row_len, in_pos.col);
                if (in_pos.row !== quad_bram_pkg::coord_t'(n_pix / row_len))
                    flag_mismatch("in_pos.row", n_pix / row_len, in_pos.row);
                n_accept   += int'(job_accept);
                n_req      += int'(job_fetch_request && !prev_req);
                n_pix      += int'(pfb_rden);
                n_reads    += int'(seq_rd.rden);
                n_complete += int'(job_complete && !prev_complete);
            end
            prev_req      = job_fetch_request;
            prev_complete = job_complete;
        end
    end

    // Fetcher answers each request with ack, then complete
    initial begin : fetcher
        forever begin
            @(posedge clk);
            if (!rst && job_fetch_request) begin
                repeat (pick(1, 5) - 1) @(posedge clk);
                job_fetch_ack <= 1'b1;
                @(posedge clk);
                job_fetch_ack <= 1'b0;
                repeat (pick(1, 8) - 1) @(posedge clk);
                job_fetch_complete <= 1'b1;
                @(posedge clk);
                job_fetch_complete <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : jobs
        int cols;
        int rows;
        int total_reads;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        for (int job = 0; job < NUM_JOBS; job++) begin
            cols = pick(2, 9);
            rows = pick(4, 7);
            total_reads = (rows - 1) * (cols + 1) * quad_bram_pkg::READS_PER_COL;
            cfg.num_input_cols <= quad_bram_pkg::coord_t'(cols);
            cfg.num_input_rows <= quad_bram_pkg::coord_t'(rows);
            pfb_full_count     <= quad_bram_pkg::pfb_count_t'(cols + 1);
            job_start          <= 1'b1;
            @(posedge clk);
            job_start <= 1'b0;
            while (n_reads < total_reads) @(posedge clk);
            repeat (pick(1, 10)) @(posedge clk);
            pipeline_flushed <= 1'b1;
            while (!job_complete) @(posedge clk);
            repeat (pick(0, 5)) @(posedge clk);
            job_complete_ack <= 1'b1;
            @(posedge clk);
            job_complete_ack <= 1'b0;
            pipeline_flushed <= 1'b0;
            @(negedge clk);
            if (job_complete) note_failure("job_complete still high after job_complete_ack");
            repeat (3) @(posedge clk);
            if (n_accept != 1) flag_mismatch("job_accept pulses", 1, n_accept);
            if (n_complete != 1) flag_mismatch("job_complete rises", 1, n_complete);
            if (n_req != rows + 1) flag_mismatch("job_fetch_request rises", rows + 1, n_req);
            if (n_pix != (rows + 1) * (cols + 1))
                flag_mismatch("pfb_rden pulses", (rows + 1) * (cols + 1), n_pix);
            if (n_reads != total_reads) flag_mismatch("seq_rd.rden reads", total_reads, n_reads);
            if (seq_rd.addr !== '0) flag_mismatch("seq_rd.addr after job", 0, seq_rd.addr);
            if (gray_code !== '0) flag_mismatch("gray_code after job", 0, gray_code);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/quad_bram_pkg.sv
source/layer_ctrl_fsm.sv
source/fetch_handshake.sv
source/pfb_drain.sv
source/seq_scan.sv
source/ce_launch_chain.sv
source/quad_bram_ctrl.sv
bench/ctrl_ref_model.sv
bench/tb_quad_bram_ctrl.sv
